//--- hw/input_filter.sv
// ################################################
// one asynchronous level input: synchronizer,
// minimum width filter and edge pulses
// edge pulse comes width + 3 clocks after a change
// ################################################
module input_filter
    import trig_cfg_pkg::*, trig_ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             trig_en,
    input  logic [cnt_w-1:0] width,
    input  logic             din,
    output logic             rise,
    output logic             fall
);

    logic [sync_depth-1:0] sync;
    logic                  din_s;      // synchronized input
    logic [cnt_w-1:0]      width_eff;
    logic [cnt_w-1:0]      stable_cnt; // cycles the input has differed from level
    logic                  level;      // filtered level
    logic                  level_d;
    logic                  differ;
    logic                  settle;

    assign din_s     = sync[sync_depth-1];
    assign width_eff = (width == '0) ? cnt_w'(1) : width; // 0 behaves as 1
    assign differ    = (din_s != level);
    assign settle    = differ && (stable_cnt == width_eff - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync <= '0;
        end else begin
            sync <= {sync[sync_depth-2:0], din};
        end
    end

    // level follows the input only after width stable cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stable_cnt <= '0;
            level      <= 1'b0;
        end else if (!trig_en) begin
            stable_cnt <= '0;
            level      <= 1'b0;
        end else if (settle) begin
            stable_cnt <= '0;
            level      <= din_s;
        end else if (differ) begin
            stable_cnt <= stable_cnt + 1'b1;
        end else begin
            stable_cnt <= '0;   // glitch ended early, start over
        end
    end

    // edge pulses one cycle after the level changes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level_d <= 1'b0;
            rise    <= 1'b0;
            fall    <= 1'b0;
        end else if (!trig_en) begin
            level_d <= 1'b0;
            rise    <= 1'b0;
            fall    <= 1'b0;
        end else begin
            level_d <= level;
            rise    <= level & ~level_d;
            fall    <= ~level & level_d;
        end
    end

endmodule

//--- hw/trig_cfg_pkg.sv
// ################################################
// configuration widths, limits and trigger modes
// all settings are one cnt_w word and must stay
// steady while trig_en is high
// ################################################
package trig_cfg_pkg;

    // width of cycle, num, delay, width and of the internal counters
    localparam int unsigned cnt_w = 16;

    // shortest pulse period, smaller cycle settings are raised to this
    localparam logic [cnt_w-1:0] min_cycle = cnt_w'(2);

    // trigger mode codes
    // the unused fourth code keeps the generator idle
    typedef enum logic [1:0] {
        mode_start_stop = 2'd0, // primary rise starts, secondary rise stops
        mode_burst      = 2'd1, // primary rise starts num pulses
        mode_gate       = 2'd2  // primary high level gates the run
    } trig_mode_e;

endpackage

//--- hw/trig_ctrl_pkg.sv
// ################################################
// run control definitions shared by the filters,
// the state machine and the timer
// ################################################
package trig_ctrl_pkg;

    // flops in each input synchronizer, at least 2
    localparam int unsigned sync_depth = 2;

    // run state, the fourth code is never entered
    typedef enum logic [1:0] {
        st_idle  = 2'd0, // waiting for a start event
        st_delay = 2'd1, // counting the start delay
        st_run   = 2'd2  // issuing trigger pulses
    } run_state_e;

endpackage

//--- hw/trig_fsm.sv
// ################################################
// run state machine: picks start and stop events
// from mode and src_sel, src_sel = 1 makes in_b
// the primary input; the fourth mode code stays idle
// ################################################
module trig_fsm
    import trig_cfg_pkg::*, trig_ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             trig_en,
    input  trig_mode_e       mode,
    input  logic             src_sel,
    input  logic [cnt_w-1:0] num,
    input  logic             a_rise,
    input  logic             a_fall,
    input  logic             b_rise,
    input  logic             b_fall,
    input  logic             delay_done,
    input  logic [cnt_w-1:0] pulse_cnt,
    output run_state_e       state
);

    logic             pri_rise;
    logic             pri_fall;
    logic             sec_rise;
    logic [cnt_w-1:0] num_eff;
    logic             start_ev;
    logic             stop_ev;
    logic             abort_ev; // gate closed before the delay ran out
    run_state_e       state_nxt;

    // primary and secondary input by src_sel
    assign pri_rise = src_sel ? b_rise : a_rise;
    assign pri_fall = src_sel ? b_fall : a_fall;
    assign sec_rise = src_sel ? a_rise : b_rise;

    assign num_eff = (num == '0) ? cnt_w'(1) : num;

    always_comb begin
        start_ev = 1'b0;
        stop_ev  = 1'b0;
        abort_ev = 1'b0;
        case (mode)
            mode_start_stop: begin
                start_ev = pri_rise;
                stop_ev  = sec_rise;
            end
            mode_burst: begin
                start_ev = pri_rise;
                stop_ev  = (pulse_cnt == num_eff); // seen the cycle after the last pulse
            end
            mode_gate: begin
                start_ev = pri_rise;
                stop_ev  = pri_fall;
                abort_ev = pri_fall;
            end
            default: begin
                start_ev = 1'b0; // idle code
            end
        endcase
    end

    always_comb begin
        state_nxt = state;
        if (!trig_en) begin
            state_nxt = st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start_ev) begin
                        state_nxt = st_delay;
                    end
                end
                st_delay: begin
                    if (abort_ev) begin
                        state_nxt = st_idle;
                    end else if (delay_done) begin
                        state_nxt = st_run;
                    end
                end
                st_run: begin
                    if (stop_ev) begin
                        state_nxt = st_idle;
                    end
                end
                default: state_nxt = st_idle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

//--- hw/trig_timer.sv
// ################################################
// start delay and pulse period counter, trigger
// output and pulse count; periods below min_cycle
// are raised to min_cycle
// ################################################
module trig_timer
    import trig_cfg_pkg::*, trig_ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  run_state_e       state,
    input  logic [cnt_w-1:0] delay,
    input  logic [cnt_w-1:0] cycle,
    output logic             delay_done,
    output logic [cnt_w-1:0] pulse_cnt,
    output logic             trig
);

    run_state_e       state_q;
    logic [cnt_w-1:0] cnt;       // delay count, then period count
    logic [cnt_w-1:0] cnt_now;
    logic [cnt_w-1:0] period;
    logic             period_end;
    logic             trig_q;

    assign period = (cycle < min_cycle) ? min_cycle : cycle;

    // count restarts from zero in the first cycle of every state
    assign cnt_now    = (state != state_q) ? '0 : cnt;
    assign delay_done = (state == st_delay) && (cnt_now == delay);
    assign period_end = (cnt_now == period - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= st_idle;
            cnt     <= '0;
        end else begin
            state_q <= state;
            case (state)
                st_delay: cnt <= cnt_now + 1'b1;
                st_run:   cnt <= period_end ? '0 : cnt_now + 1'b1;
                default:  cnt <= '0;
            endcase
        end
    end

    // pulse one cycle ahead: into the first run cycle, then each period
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trig_q <= 1'b0;
        end else begin
            trig_q <= delay_done || ((state == st_run) && period_end);
        end
    end

    // a pulse prepared just before the run ended is dropped
    assign trig = trig_q && (state == st_run);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pulse_cnt <= '0;
        end else if (state == st_idle) begin
            pulse_cnt <= '0;
        end else if (trig) begin
            pulse_cnt <= pulse_cnt + 1'b1;
        end
    end

endmodule

//--- hw/trig_top.sv
// ################################################
// trigger generator top: two input filters, run
// state machine and timer; first pulse comes
// width + delay + 5 clocks after the start change
// ################################################
module trig_top
    import trig_cfg_pkg::*, trig_ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             trig_en,
    input  trig_mode_e       mode,
    input  logic             src_sel,
    input  logic [cnt_w-1:0] cycle,
    input  logic [cnt_w-1:0] num,
    input  logic [cnt_w-1:0] delay,
    input  logic [cnt_w-1:0] width,
    input  logic             in_a,
    input  logic             in_b,
    output logic             trig
);

    logic             a_rise;
    logic             a_fall;
    logic             b_rise;
    logic             b_fall;
    logic             delay_done;
    logic [cnt_w-1:0] pulse_cnt;
    run_state_e       state;

    input_filter i_filt_a (
        .clk     (clk),
        .rst     (rst),
        .trig_en (trig_en),
        .width   (width),
        .din     (in_a),
        .rise    (a_rise),
        .fall    (a_fall)
    );

    input_filter i_filt_b (
        .clk     (clk),
        .rst     (rst),
        .trig_en (trig_en),
        .width   (width),
        .din     (in_b),
        .rise    (b_rise),
        .fall    (b_fall)
    );

    trig_fsm i_fsm (
        .clk        (clk),
        .rst        (rst),
        .trig_en    (trig_en),
        .mode       (mode),
        .src_sel    (src_sel),
        .num        (num),
        .a_rise     (a_rise),
        .a_fall     (a_fall),
        .b_rise     (b_rise),
        .b_fall     (b_fall),
        .delay_done (delay_done),
        .pulse_cnt  (pulse_cnt),
        .state      (state)
    );

    trig_timer i_timer (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .delay      (delay),
        .cycle      (cycle),
        .delay_done (delay_done),
        .pulse_cnt  (pulse_cnt),
        .trig       (trig)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the trigger generator testbench with Verilator, run it and
# look for the pass message in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module trig_tb -f trig.f -o trig_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/trig_sim +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -qx "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/trig_chk.sv
// ################################################
// assertions bound to trig_top that see only its ports
// a model of filter, run state and pulse times
// predicts every trig cycle and samples at negedge
// ################################################
module trig_chk
    import trig_cfg_pkg::*, trig_ctrl_pkg::*;
(
    input logic             clk,
    input logic             rst,
    input logic             trig_en,
    input trig_mode_e       mode,
    input logic             src_sel,
    input logic [cnt_w-1:0] cycle,
    input logic [cnt_w-1:0] num,
    input logic [cnt_w-1:0] delay,
    input logic [cnt_w-1:0] width,
    input logic             in_a,
    input logic             in_b,
    input logic             trig
);

    int unsigned      err_cnt = 0; // count of failed assertions
    logic [1:0]       raw;
    logic [1:0]       lvl;         // model filtered level per input
    logic [cnt_w-1:0] fcnt [2];
    logic [3:0]       rise_p [2];  // edges on their way to the state machine
    logic [3:0]       fall_p [2];
    logic [cnt_w-1:0] w_eff;
    logic [cnt_w-1:0] n_eff;
    logic [cnt_w-1:0] per;
    logic             pri_rise;
    logic             pri_fall;
    logic             sec_rise;
    logic             start;
    logic             stop;
    run_state_e       m_st;
    logic [cnt_w-1:0] m_cnt;       // delay count
    logic [cnt_w-1:0] m_ph;        // phase inside the pulse period
    logic [cnt_w-1:0] m_pc;        // pulses issued in this run
    logic [cnt_w-1:0] b_pc;        // trig pulses seen since the last start
    logic             en_q;
    logic             due;         // a pulse is expected in this cycle

    assign raw      = {in_b, in_a};
    assign w_eff    = (width == '0) ? cnt_w'(1) : width;
    assign n_eff    = (num == '0) ? cnt_w'(1) : num;
    assign per      = (cycle < min_cycle) ? min_cycle : cycle;
    assign pri_rise = src_sel ? rise_p[1][3] : rise_p[0][3];
    assign pri_fall = src_sel ? fall_p[1][3] : fall_p[0][3];
    assign sec_rise = src_sel ? rise_p[0][3] : rise_p[1][3];
    assign start    = pri_rise && (mode inside {mode_start_stop, mode_burst, mode_gate});
    assign stop     = ((mode == mode_start_stop) && sec_rise)
                   || ((mode == mode_burst) && (m_pc == n_eff))
                   || ((mode == mode_gate) && pri_fall);
    assign due      = (m_st == st_run) && (m_ph == '0);

    // level changes once the sampled input held a new value for width samples
    // and the edge reaches the run logic four cycles later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvl  <= '0;
            en_q <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                fcnt[i]   <= '0;
                rise_p[i] <= '0;
                fall_p[i] <= '0;
            end
        end else begin
            en_q <= trig_en;
            for (int i = 0; i < 2; i++) begin
                rise_p[i] <= {rise_p[i][2:0], 1'b0};
                fall_p[i] <= {fall_p[i][2:0], 1'b0};
                if (!trig_en) begin
                    lvl[i]    <= 1'b0;
                    fcnt[i]   <= '0;
                    rise_p[i] <= '0;
                    fall_p[i] <= '0;
                end else if (raw[i] != lvl[i]) begin
                    if (fcnt[i] + 1'b1 == w_eff) begin
                        lvl[i]    <= raw[i];
                        fcnt[i]   <= '0;
                        rise_p[i] <= {rise_p[i][2:0], raw[i]};
                        fall_p[i] <= {fall_p[i][2:0], ~raw[i]};
                    end else begin
                        fcnt[i] <= fcnt[i] + 1'b1;
                    end
                end else begin
                    fcnt[i] <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_st  <= st_idle;
            m_cnt <= '0;
            m_ph  <= '0;
            m_pc  <= '0;
        end else begin
            m_pc  <= (m_st == st_idle) ? '0 : m_pc + cnt_w'(due);
            m_cnt <= m_cnt + 1'b1;
            m_ph  <= (m_ph == per - 1'b1) ? '0 : m_ph + 1'b1;
            if (!trig_en) begin
                m_st <= st_idle;
            end else if ((m_st == st_idle) && start) begin
                m_st  <= st_delay;
                m_cnt <= '0;
            end else if (m_st == st_delay) begin
                if ((mode == mode_gate) && pri_fall) begin
                    m_st <= st_idle;
                end else if (m_cnt == delay) begin
                    m_st <= st_run;
                    m_ph <= '0;  // first pulse in the first run cycle
                end
            end else if ((m_st == st_run) && stop) begin
                m_st <= st_idle;
            end
        end
    end

    // actual pulses on trig, kept after the run ends until the next start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            b_pc <= '0;
        end else if (!trig_en || ((m_st == st_idle) && start)) begin
            b_pc <= '0;
        end else begin
            b_pc <= b_pc + cnt_w'(trig);
        end
    end

    a_en_low: assert property (@(negedge clk) disable iff (rst)
        (!trig_en && !en_q) |-> !trig)
        else begin
            err_cnt++;
            $error("trig high while the generator is disabled");
        end

    a_first: assert property (@(negedge clk) disable iff (rst)
        (due && (m_pc == '0)) |-> trig)
        else begin
            err_cnt++;
            $error("first trig pulse missing at width + delay + 5");
        end

    a_period: assert property (@(negedge clk) disable iff (rst)
        (due && (m_pc != '0)) |-> trig)
        else begin
            err_cnt++;
            $error("trig pulse missing one period after the last");
        end

    a_no_extra: assert property (@(negedge clk) disable iff (rst)
        !due |-> !trig)
        else begin
            err_cnt++;
            $error("trig pulse outside the expected pulse times");
        end

    a_burst_len: assert property (@(negedge clk) disable iff (rst)
        ((mode == mode_burst) && trig) |-> (b_pc < n_eff))
        else begin
            err_cnt++;
            $error("burst gave more than num pulses for one start");
        end

endmodule

bind trig_top trig_chk i_chk (.*);

//--- sim/trig_tb.sv
// ################################################
// trigger generator testbench, checking is done by
// the bound assertions in trig_chk; inputs change
// 10 units after the rising clock edge
// ################################################
module trig_tb
    import trig_cfg_pkg::*;
();

    localparam int clk_period = 100;
    localparam int w_max      = 4;   // largest width used by the tests
    localparam int d_max      = 6;
    localparam int c_max      = 9;
    localparam int n_max      = 5;
    localparam int num_tests  = 7;
    localparam int test_max   = 2 * (w_max + d_max + 10 + (n_max + 4) * c_max) + 60;
    localparam int wd_cycles  = num_tests * test_max + 16 + 50;

    logic             clk = 1'b0;
    logic             rst;
    logic             trig_en;
    trig_mode_e       mode;
    logic             src_sel;
    logic [cnt_w-1:0] cycle;
    logic [cnt_w-1:0] num;
    logic [cnt_w-1:0] delay;
    logic [cnt_w-1:0] width;
    logic             in_a;
    logic             in_b;
    logic             trig;
    int               tb_err = 0;
    int               err_base = 0;
    int               tests_run = 0;
    int               tests_failed = 0;

    trig_top i_trig_top (
        .clk     (clk),
        .rst     (rst),
        .trig_en (trig_en),
        .mode    (mode),
        .src_sel (src_sel),
        .cycle   (cycle),
        .num     (num),
        .delay   (delay),
        .width   (width),
        .in_a    (in_a),
        .in_b    (in_b),
        .trig    (trig)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic int filter_width();
        return (width == '0) ? 1 : int'(width);
    endfunction

    function automatic int pulse_period();
        return (cycle < min_cycle) ? int'(min_cycle) : int'(cycle);
    endfunction

    // input change to first pulse
    function automatic int first_pulse();
        return filter_width() + int'(delay) + 5;
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic drive_primary(input logic v);
        if (src_sel) in_b = v;
        else in_a = v;
    endtask

    task automatic drive_secondary(input logic v);
        if (src_sel) in_a = v;
        else in_b = v;
    endtask

    task automatic observe(input int n, output int pulses);
        pulses = 0;
        repeat (n) begin
            step(1);
            if (trig) pulses++;
        end
    endtask

    task automatic wait_pulses(input int target, input int limit, output int pulses);
        int waited;
        pulses = 0;
        waited = 0;
        while (pulses < target && waited < limit) begin
            step(1);
            if (trig) pulses++;
            waited++;
        end
        if (pulses < target) begin
            $display("burst did not finish: %0d of %0d pulses after %0d cycles",
                     pulses, target, waited);
            tb_err++;
        end
    endtask

    // random timing, configuration only changes while disabled
    task automatic configure(input trig_mode_e m, input logic sel, input int w);
        mode    = m;
        src_sel = sel;
        width   = cnt_w'(w);
        cycle   = cnt_w'($urandom_range(9, 2));
        delay   = cnt_w'($urandom_range(6, 0));
        num     = cnt_w'($urandom_range(5, 1));
        trig_en = 1'b1;
        step(2);
    endtask

    task automatic release_inputs();
        in_a = 1'b0;
        in_b = 1'b0;
        step(filter_width() + 8);  // let the fall edges drain
        trig_en = 1'b0;
        step(2);
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = tb_err + int'(i_trig_top.i_chk.err_cnt) - err_base;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errs);
        end
        err_base = tb_err + int'(i_trig_top.i_chk.err_cnt);
    endtask

    initial begin
        #(wd_cycles * clk_period);
        $display("watchdog: run did not end within %0d cycles", wd_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int got;
        int extra;
        int total;
        void'($urandom(39));
        rst     = 1'b1;
        trig_en = 1'b0;
        mode    = mode_start_stop;
        src_sel = 1'b0;
        cycle   = cnt_w'(2);
        num     = cnt_w'(1);
        delay   = '0;
        width   = cnt_w'(1);
        in_a    = 1'b0;
        in_b    = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;
        step(2);

        // both inputs toggle with the generator disabled
        mode = mode_burst;
        repeat (2) begin
            in_a = 1'b1;
            in_b = 1'b1;
            step(10);
            in_a = 1'b0;
            in_b = 1'b0;
            step(10);
        end
        finish_test("disabled");

        for (int sel = 0; sel < 2; sel++) begin
            configure(mode_start_stop, sel[0], (sel == 0) ? 3 : 0);
            drive_primary(1'b1);
            observe(first_pulse() + 3 * pulse_period(), got);
            drive_secondary(1'b1);
            observe(filter_width() + 5 + 2 * pulse_period(), got);
            release_inputs();
            finish_test((sel == 0) ? "start_stop a" : "start_stop b");
        end

        for (int sel = 0; sel < 2; sel++) begin
            configure(mode_burst, sel[0], 3);
            repeat (2) begin
                drive_primary(1'b1);
                wait_pulses(int'(num), first_pulse() + (int'(num) + 1) * pulse_period(), got);
                observe(filter_width() + 5 + 2 * pulse_period(), extra);
                if (got + extra != int'(num)) begin
                    $display("[FAIL] t=%0t trig pulses: got %0d expected %0d",
                             $time, got + extra, num);
                    tb_err++;
                end
                drive_primary(1'b0);
                step(filter_width() + 5);
            end
            release_inputs();
            finish_test((sel == 0) ? "burst a" : "burst b");
        end

        // gate on in_b, closed once and opened again
        configure(mode_gate, 1'b1, 2);
        drive_primary(1'b1);
        observe(first_pulse() + 3 * pulse_period(), got);
        drive_primary(1'b0);
        observe(filter_width() + 5 + 2 * pulse_period(), got);
        drive_primary(1'b1);
        observe(first_pulse() + 2 * pulse_period(), got);
        drive_primary(1'b0);
        observe(filter_width() + 5 + pulse_period(), got);
        release_inputs();
        finish_test("gate");

        // glitches of 1 and width - 1 cycles must not start a run
        configure(mode_burst, 1'b0, 4);
        in_a = 1'b1;
        step(1);
        in_a = 1'b0;
        observe(first_pulse() + 5, got);
        in_a = 1'b1;
        step(filter_width() - 1);
        in_a = 1'b0;
        observe(first_pulse() + 5, got);
        release_inputs();
        finish_test("glitch");

        total = tb_err + int'(i_trig_top.i_chk.err_cnt);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- trig.f
hw/trig_cfg_pkg.sv
hw/trig_ctrl_pkg.sv
hw/input_filter.sv
hw/trig_fsm.sv
hw/trig_timer.sv
hw/trig_top.sv
sim/trig_chk.sv
sim/trig_tb.sv
